// ==== blob_sort_pkg.sv ====
package blob_sort_pkg;

	// main-memory bus, read only from the ranker's side
	typedef logic [17:0] mem_addr_t;
	typedef logic [31:0] mem_word_t;

	// ranking key, either blob size or y centroid zero-extended
	typedef logic [15:0] blob_key_t;

	// address of word 0 of a record in main memory
	typedef logic [17:0] blob_ptr_t;

	// entry index into the 18-entry rank tables
	typedef logic [4:0] slot_idx_t;

	typedef logic [7:0] color_t;
	typedef logic [15:0] blob_count_t;

	// number of blobs passing both filters, wraps on overflow
	typedef logic [7:0] valid_count_t;

	typedef enum logic {
		mode_biggest = 1'b0,
		mode_highest = 1'b1
	} sort_mode_e;

	// controller states, one record in flight at a time
	typedef enum logic [3:0] {
		st_idle,
		st_clear,
		st_word0,
		st_check_color,
		st_word1,
		st_check_size,
		st_read_rank,
		st_compare,
		st_shift,
		st_insert,
		st_done
	} sort_state_e;

	// record table left behind by blob extraction
	localparam mem_addr_t BLOB_BASE = 18'd200000;
	localparam int WORDS_PER_BLOB = 3;

	// word 1 layout is x [31:24], y [23:16], size [15:0]
	localparam int Y_LSB = 16;

	// colour slots 1..6, three ranks each
	localparam int NUM_COLORS = 6;
	localparam int NUM_RANKS = 3;
	localparam int TABLE_DEPTH = NUM_COLORS * NUM_RANKS;

	// pointer value marking an unused table entry
	localparam blob_ptr_t PTR_EMPTY = '1;

endpackage

// ==== blob_sort_ctrl.sv ====
`timescale 1ns/100ps

module blob_sort_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      enable,
	input  logic                      find_highest,
	input  logic                      color_ok,
	input  logic                      size_ok,
	input  logic                      scan_end,
	input  logic                      clear_busy,
	input  logic                      new_better,
	output logic                      fetch_start,
	output logic                      fetch_word0,
	output logic                      fetch_word1,
	output logic                      clear_start,
	output logic                      table_read,
	output logic                      table_shift,
	output logic                      table_insert,
	output logic [1:0]                rank_sel,
	output blob_sort_pkg::sort_mode_e mode,
	output logic                      sort_done
);
	import blob_sort_pkg::*;

	localparam logic [1:0] LAST_RANK = 2'(NUM_RANKS - 1);

	sort_state_e state;
	sort_state_e state_nxt;
	logic enable_d;
	logic start;
	// rank under test, later the rank the new blob goes to
	logic [1:0] rank;
	logic [1:0] rank_nxt;
	// destination of the shift in progress, walks upward
	logic [1:0] dst;
	logic [1:0] dst_nxt;
	// first or second cycle of a table write
	logic step;
	logic step_nxt;

	// a pass begins on the rising edge of enable only
	assign start = enable && !enable_d;

	assign sort_done = (state == st_done);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			enable_d <= 1'b0;
			rank <= '0;
			dst <= '0;
			step <= 1'b0;
			mode <= mode_biggest;
		end else begin
			state <= state_nxt;
			enable_d <= enable;
			rank <= rank_nxt;
			dst <= dst_nxt;
			step <= step_nxt;
			// mode is frozen for the whole pass
			if (state == st_idle && start) begin
				mode <= find_highest ? mode_highest : mode_biggest;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		rank_nxt = rank;
		dst_nxt = dst;
		step_nxt = step;
		fetch_start = 1'b0;
		fetch_word0 = 1'b0;
		fetch_word1 = 1'b0;
		clear_start = 1'b0;
		table_read = 1'b0;
		table_shift = 1'b0;
		table_insert = 1'b0;
		rank_sel = rank;
		case (state)
			st_idle: begin
				if (start) begin
					fetch_start = 1'b1;
					clear_start = 1'b1;
					state_nxt = st_clear;
				end
			end
			// clear_busy drops in the last clear cycle
			st_clear: begin
				if (!clear_busy) begin
					state_nxt = st_word0;
				end
			end
			st_word0: begin
				if (scan_end) begin
					state_nxt = st_done;
				end else begin
					fetch_word0 = 1'b1;
					state_nxt = st_check_color;
				end
			end
			// rejected colour goes straight to the next record
			st_check_color: begin
				state_nxt = color_ok ? st_word1 : st_word0;
			end
			st_word1: begin
				fetch_word1 = 1'b1;
				state_nxt = st_check_size;
			end
			st_check_size: begin
				if (size_ok) begin
					rank_nxt = '0;
					state_nxt = st_read_rank;
				end else begin
					state_nxt = st_word0;
				end
			end
			st_read_rank: begin
				table_read = 1'b1;
				state_nxt = st_compare;
			end
			st_compare: begin
				if (new_better) begin
					step_nxt = 1'b0;
					dst_nxt = LAST_RANK;
					// worst rank wins need no shifting
					state_nxt = (rank == LAST_RANK) ? st_insert : st_shift;
				end else if (rank == LAST_RANK) begin
					// lost against all three ranks
					state_nxt = st_word0;
				end else begin
					rank_nxt = rank + 2'd1;
					state_nxt = st_read_rank;
				end
			end
			// read rank dst-1, then write it into dst
			st_shift: begin
				if (!step) begin
					table_read = 1'b1;
					rank_sel = dst - 2'd1;
					step_nxt = 1'b1;
				end else begin
					table_shift = 1'b1;
					rank_sel = dst;
					step_nxt = 1'b0;
					if (dst == rank + 2'd1) begin
						state_nxt = st_insert;
					end else begin
						dst_nxt = dst - 2'd1;
					end
				end
			end
			// insert also spans two cycles, same cost as a shift
			st_insert: begin
				if (!step) begin
					table_insert = 1'b1;
					step_nxt = 1'b1;
				end else begin
					step_nxt = 1'b0;
					state_nxt = st_word0;
				end
			end
			// hold the done level until enable falls
			st_done: begin
				state_nxt = st_done;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
		// dropping enable abandons the pass from any state
		if (!enable) begin
			state_nxt = st_idle;
		end
	end

endmodule

// ==== blob_fetch.sv ====
`timescale 1ns/100ps

module blob_fetch (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        fetch_start,
	input  logic                        fetch_word0,
	input  logic                        fetch_word1,
	input  blob_sort_pkg::sort_mode_e   mode,
	input  blob_sort_pkg::blob_key_t    min_size,
	input  blob_sort_pkg::blob_count_t  blob_count,
	input  blob_sort_pkg::mem_word_t    data_read,
	output blob_sort_pkg::mem_addr_t    address,
	output logic                        color_ok,
	output logic                        size_ok,
	output logic                        scan_end,
	output blob_sort_pkg::blob_key_t    new_key,
	output blob_sort_pkg::blob_ptr_t    new_ptr,
	output blob_sort_pkg::color_t       new_color,
	output blob_sort_pkg::valid_count_t valid_blobs
);
	import blob_sort_pkg::*;

	// word offset of the current record from BLOB_BASE
	mem_addr_t rec_off;
	blob_count_t rec_idx;
	// data_read holds the word requested one cycle earlier
	logic word0_pend;
	logic word1_pend;
	logic advance;
	color_t rd_color;
	blob_key_t rd_size;
	logic [7:0] rd_y;

	assign rd_color = data_read[7:0];
	assign rd_size = data_read[15:0];
	assign rd_y = data_read[Y_LSB +: 8];

	// only slots 1..NUM_COLORS are tracked
	assign color_ok = (rd_color != '0) && (rd_color <= color_t'(NUM_COLORS));
	assign size_ok = (rd_size >= min_size);
	assign scan_end = (rec_idx == blob_count);

	// record done when colour fails, or once word 1 has been judged
	assign advance = (word0_pend && !color_ok) || word1_pend;

	always_ff @(posedge clk) begin
		if (rst) begin
			word0_pend <= 1'b0;
			word1_pend <= 1'b0;
			rec_off <= '0;
			rec_idx <= '0;
			address <= '0;
			valid_blobs <= '0;
		end else begin
			word0_pend <= fetch_word0;
			word1_pend <= fetch_word1;
			if (fetch_start) begin
				rec_off <= '0;
				rec_idx <= '0;
				address <= BLOB_BASE;
				valid_blobs <= '0;
			end else begin
				// word 0 is on the bus already, move on to word 1
				if (fetch_word0) begin
					address <= BLOB_BASE + rec_off + mem_addr_t'(1);
				end
				// park the address on word 0 of the next record
				if (advance) begin
					rec_off <= rec_off + mem_addr_t'(WORDS_PER_BLOB);
					rec_idx <= rec_idx + 16'd1;
					address <= BLOB_BASE + rec_off + mem_addr_t'(WORDS_PER_BLOB);
				end
				// word 1 is only requested after the colour passed
				if (word1_pend && size_ok) begin
					valid_blobs <= valid_blobs + 8'd1;
				end
			end
		end
	end

	// candidate fields for the rank table
	always_ff @(posedge clk) begin
		if (word0_pend) begin
			new_color <= rd_color;
		end
		if (word1_pend) begin
			new_ptr <= blob_ptr_t'(BLOB_BASE + rec_off);
			new_key <= (mode == mode_highest) ? blob_key_t'(rd_y) : rd_size;
		end
	end

endmodule

// ==== rank_table.sv ====
`timescale 1ns/100ps

module rank_table (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear_start,
	input  logic                     table_read,
	input  logic                     table_shift,
	input  logic                     table_insert,
	input  logic [1:0]               rank_sel,
	input  blob_sort_pkg::blob_key_t new_key,
	input  blob_sort_pkg::blob_ptr_t new_ptr,
	input  blob_sort_pkg::color_t    new_color,
	input  blob_sort_pkg::slot_idx_t ptr_rd_addr,
	output logic                     clear_busy,
	output logic                     new_better,
	output blob_sort_pkg::blob_ptr_t ptr_rd_data
);
	import blob_sort_pkg::*;

	localparam slot_idx_t LAST_SLOT = slot_idx_t'(TABLE_DEPTH - 1);

	// rank r of colour c lives at r * NUM_COLORS + (c - 1)
	blob_key_t key_mem [TABLE_DEPTH];
	blob_ptr_t ptr_mem [TABLE_DEPTH];

	slot_idx_t col_off;
	slot_idx_t idx;
	slot_idx_t clear_cnt;
	logic clear_run;
	// entry fetched by table_read, also the source of a shift
	blob_key_t rd_key;
	blob_ptr_t rd_ptr;
	// single write port shared by clear, shift and insert
	logic wr_en;
	slot_idx_t wr_idx;
	blob_key_t wr_key;
	blob_ptr_t wr_ptr;

	assign col_off = slot_idx_t'(new_color - 8'd1);
	assign idx = {3'b000, rank_sel} * slot_idx_t'(NUM_COLORS) + col_off;

	// strict compare, ties keep the earlier blob ahead
	assign new_better = (new_key > rd_key);

	// low in the final clear cycle so the controller leaves on time
	assign clear_busy = clear_run && (clear_cnt != LAST_SLOT);

	always_ff @(posedge clk) begin
		if (rst) begin
			clear_run <= 1'b0;
			clear_cnt <= '0;
		end else if (clear_start) begin
			clear_run <= 1'b1;
			clear_cnt <= '0;
		end else if (clear_run) begin
			clear_cnt <= clear_cnt + 5'd1;
			if (clear_cnt == LAST_SLOT) begin
				clear_run <= 1'b0;
			end
		end
	end

	always_comb begin
		wr_en = 1'b0;
		wr_idx = idx;
		wr_key = new_key;
		wr_ptr = new_ptr;
		if (clear_run) begin
			// one entry per cycle back to empty
			wr_en = 1'b1;
			wr_idx = clear_cnt;
			wr_key = '0;
			wr_ptr = PTR_EMPTY;
		end else if (table_shift) begin
			// demote the entry read in the previous cycle
			wr_en = 1'b1;
			wr_key = rd_key;
			wr_ptr = rd_ptr;
		end else if (table_insert) begin
			wr_en = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			key_mem[wr_idx] <= wr_key;
			ptr_mem[wr_idx] <= wr_ptr;
		end
		if (table_read) begin
			rd_key <= key_mem[idx];
			rd_ptr <= ptr_mem[idx];
		end
	end

	// second pointer port for the outside reader, one cycle latency
	always_ff @(posedge clk) begin
		if (ptr_rd_addr <= LAST_SLOT) begin
			ptr_rd_data <= ptr_mem[ptr_rd_addr];
		end else begin
			ptr_rd_data <= PTR_EMPTY;
		end
	end

endmodule

// ==== blob_sort_top.sv ====
`timescale 1ns/100ps

module blob_sort_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        enable,
	input  logic                        find_highest,
	input  blob_sort_pkg::blob_key_t    min_size,
	input  blob_sort_pkg::blob_count_t  blob_count,
	input  blob_sort_pkg::mem_word_t    data_read,
	output blob_sort_pkg::mem_addr_t    address,
	input  blob_sort_pkg::slot_idx_t    ptr_rd_addr,
	output blob_sort_pkg::blob_ptr_t    ptr_rd_data,
	output blob_sort_pkg::valid_count_t valid_blobs,
	output logic                        sort_done
);
	import blob_sort_pkg::*;

	// controller to fetcher
	logic fetch_start;
	logic fetch_word0;
	logic fetch_word1;
	logic color_ok;
	logic size_ok;
	logic scan_end;
	sort_mode_e mode;

	// controller to rank table
	logic clear_start;
	logic clear_busy;
	logic table_read;
	logic table_shift;
	logic table_insert;
	logic new_better;
	logic [1:0] rank_sel;

	// candidate record, fetcher to rank table
	blob_key_t new_key;
	blob_ptr_t new_ptr;
	color_t new_color;

	// all ports share names with the nets above
	blob_sort_ctrl i_ctrl (.*);

	blob_fetch i_fetch (.*);

	rank_table i_table (.*);

endmodule

// ==== blob_sort_sva.sv ====
`timescale 1ns/100ps

module blob_sort_sva (
	input logic                       clk,
	input logic                       rst,
	input logic                       enable,
	input logic                       sort_done,
	input logic                       table_shift,
	input logic                       table_insert,
	input blob_sort_pkg::mem_addr_t   address,
	input blob_sort_pkg::blob_count_t blob_count
);
	import blob_sort_pkg::*;

	// word 0 of the record after the last one, where the address parks
	int rec_end;
	assign rec_end = int'(BLOB_BASE) + WORDS_PER_BLOB * int'(blob_count);

	done_after_enable: assert property (@(posedge clk) disable iff (rst)
		!$past(enable) |-> !sort_done)
		else $error("sort_done high although enable was low");

	// first enabled cycle still holds the address of the previous pass
	address_in_records: assert property (@(posedge clk) disable iff (rst)
		($past(enable) && enable) |->
			(int'(address) >= int'(BLOB_BASE) && int'(address) <= rec_end))
		else $error("address outside the record area during a scan");

	one_table_write: assert property (@(posedge clk) disable iff (rst)
		!(table_shift && table_insert))
		else $error("table_shift and table_insert high together");

endmodule

bind blob_sort_top blob_sort_sva i_sva (
	.clk(clk),
	.rst(rst),
	.enable(enable),
	.sort_done(sort_done),
	.table_shift(table_shift),
	.table_insert(table_insert),
	.address(address),
	.blob_count(blob_count)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== tb_blob_sort.sv ====
`timescale 1ns/100ps

module tb_blob_sort;
	import blob_sort_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int VEC_DEPTH = 1024;
	localparam int MAX_RECS = 64;
	localparam logic [31:0] END_MARK = 32'hffffffff;

	logic clk;
	logic rst;
	logic enable;
	logic find_highest;
	blob_key_t min_size;
	blob_count_t blob_count;
	mem_word_t data_read = '0;
	mem_addr_t address;
	slot_idx_t ptr_rd_addr;
	blob_ptr_t ptr_rd_data;
	valid_count_t valid_blobs;
	logic sort_done;

	// flat word image of the vector file
	logic [31:0] vec [VEC_DEPTH];
	int vp;
	// only words 0 and 1 of a record are stored
	mem_word_t rec_w0 [MAX_RECS];
	mem_word_t rec_w1 [MAX_RECS];
	int num_recs;
	int errors;
	int tests_run;
	int tests_failed;

	tb_clock_gen i_clk (
		.clk(clk),
		.rst(rst)
	);

	blob_sort_top i_dut (.*);

	// unused words carry their own address in both halves
	function automatic mem_word_t fill_word(mem_addr_t addr);
		return {addr[13:0], addr};
	endfunction

	function automatic mem_word_t mem_word(mem_addr_t addr);
		int off;
		off = int'(addr) - int'(BLOB_BASE);
		if (off < 0 || off >= WORDS_PER_BLOB * num_recs) begin
			return fill_word(addr);
		end
		if (off % WORDS_PER_BLOB == 0) begin
			return rec_w0[off / WORDS_PER_BLOB];
		end
		if (off % WORDS_PER_BLOB == 1) begin
			return rec_w1[off / WORDS_PER_BLOB];
		end
		return fill_word(addr);
	endfunction

	// main memory returns the word the cycle after its address
	always @(posedge clk) begin
		data_read <= mem_word(address);
	end

	task automatic watchdog(int cycles);
		#(cycles * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", cycles);
		$display("** FAIL **");
		$finish;
	endtask

	// outputs once reset is released and before any pass
	task automatic check_reset();
		if (address !== '0) begin
			errors++;
			$display("Fail at %0t: address %h after reset, expected 0", $time, address);
		end
		if (sort_done !== 1'b0) begin
			errors++;
			$display("Fail at %0t: sort_done %b after reset, expected 0", $time, sort_done);
		end
		if (valid_blobs !== '0) begin
			errors++;
			$display("Fail at %0t: valid_blobs %0d after reset, expected 0",
				$time, valid_blobs);
		end
	endtask

	task automatic load_records(int count);
		for (int r = 0; r < count; r++) begin
			rec_w0[r] = vec[vp];
			rec_w1[r] = vec[vp + 1];
			vp += 2;
		end
		num_recs = count;
	endtask

	// settings and enable change on the same edge
	task automatic start_pass(logic mode, blob_key_t min_w, blob_count_t count);
		@(posedge clk);
		find_highest <= mode;
		min_size <= min_w;
		blob_count <= count;
		enable <= 1'b1;
	endtask

	task automatic wait_done();
		@(negedge clk);
		while (!sort_done) @(negedge clk);
	endtask

	// read port has one cycle of latency
	task automatic check_table(int num);
		blob_ptr_t exp;
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			@(posedge clk);
			ptr_rd_addr <= slot_idx_t'(i);
			@(posedge clk);
			@(negedge clk);
			exp = blob_ptr_t'(vec[vp]);
			vp++;
			if (ptr_rd_data !== exp) begin
				errors++;
				$display("Fail at %0t: test %0d slot %0d pointer %h, expected %h",
					$time, num, i, ptr_rd_data, exp);
			end
		end
	endtask

	task automatic check_valid(int num);
		valid_count_t exp;
		exp = valid_count_t'(vec[vp]);
		vp++;
		if (valid_blobs !== exp) begin
			errors++;
			$display("Fail at %0t: test %0d valid_blobs %0d, expected %0d",
				$time, num, valid_blobs, exp);
		end
	endtask

	// done level must be gone one cycle after enable drops
	task automatic end_pass(int num);
		@(posedge clk);
		enable <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		if (sort_done !== 1'b0) begin
			errors++;
			$display("Fail at %0t: test %0d sort_done still high after enable fell",
				$time, num);
		end
	endtask

	task automatic abort_pass(int num, int cycles);
		repeat (cycles) @(negedge clk);
		if (sort_done) begin
			errors++;
			$display("test %0d: the pass ended before enable was dropped", num);
		end
		end_pass(num);
	endtask

	// header is mode, min_size, count, abort cycles
	task automatic run_test(int num);
		logic [31:0] mode_w;
		blob_key_t min_w;
		int count;
		int abort_cycles;
		int errs_before;
		mode_w = vec[vp];
		min_w = blob_key_t'(vec[vp + 1]);
		count = int'(vec[vp + 2]);
		abort_cycles = int'(vec[vp + 3]);
		vp += 4;
		errs_before = errors;
		load_records(count);
		start_pass(mode_w[0], min_w, blob_count_t'(count));
		if (abort_cycles > 0) begin
			abort_pass(num, abort_cycles);
			$display("test %0d: pass dropped after %0d cycles", num, abort_cycles);
		end else begin
			wait_done();
			// the file lists the pointers first, then the valid count
			check_table(num);
			check_valid(num);
			end_pass(num);
			$display("test %0d %s: %0d records, %0d mismatches", num,
				mode_w[0] ? "highest" : "biggest", count, errors - errs_before);
		end
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
		end
	endtask

	initial begin
		int ntests;
		int nrecs;
		int n;
		enable = 1'b0;
		find_highest = 1'b0;
		min_size = '0;
		blob_count = '0;
		ptr_rd_addr = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		num_recs = 0;
		ntests = 0;
		nrecs = 0;
		$readmemh("blob_sort_vectors.txt", vec);
		// first walk only sizes the watchdog
		vp = 0;
		while (vec[vp] != END_MARK && vp < VEC_DEPTH - 32) begin
			n = int'(vec[vp + 2]);
			ntests++;
			nrecs += n;
			if (vec[vp + 3] == 32'd0) begin
				vp += 4 + 2 * n + TABLE_DEPTH + 1;
			end else begin
				vp += 4 + 2 * n;
			end
		end
		if (ntests == 0) begin
			errors++;
			$display("no tests found in blob_sort_vectors.txt");
		end
		fork
			watchdog(100 * nrecs + 200 * ntests + 20);
		join_none
		@(negedge clk);
		while (rst) @(negedge clk);
		check_reset();
		vp = 0;
		for (int t = 1; t <= ntests; t++) begin
			run_test(t);
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== blob_sort_vectors.txt ====
// test: mode min_size count abort_cycles, then count records as word0 word1,
// then (abort 0 only) pointers by table index, one rank per row, and valid count
// 1: biggest, colour 2, five sizes
0 10 5 0
00000002 11100040 00000002 22050100 00000002 33800020
00000002 44300200 00000002 55600080
3ffff 30d49 3ffff 3ffff 3ffff 3ffff
3ffff 30d43 3ffff 3ffff 3ffff 3ffff
3ffff 30d4c 3ffff 3ffff 3ffff 3ffff
5
// 2: highest, same records, ranked by y
1 10 5 0
00000002 11100040 00000002 22050100 00000002 33800020
00000002 44300200 00000002 55600080
3ffff 30d46 3ffff 3ffff 3ffff 3ffff
3ffff 30d4c 3ffff 3ffff 3ffff 3ffff
3ffff 30d49 3ffff 3ffff 3ffff 3ffff
5
// 3: colour 0, colour 7, colour ff and a small size are rejected
0 40 6 0
00000000 66000500 00000007 66000500 00000001 66000030
00000001 66000040 abcd0006 66000100 000000ff 66000600
30d49 3ffff 3ffff 3ffff 3ffff 30d4c
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
2
// 4: equal sizes keep arrival order, fourth 50 is dropped
0 0 5 0
00000003 01020050 00000003 02030050 00000003 03040070
00000003 04050050 00000003 05060010
3ffff 3ffff 30d46 3ffff 3ffff 3ffff
3ffff 3ffff 30d40 3ffff 3ffff 3ffff
3ffff 3ffff 30d43 3ffff 3ffff 3ffff
5
// 5: highest, enable dropped after 45 cycles
1 0 4 2d
00000006 10900008 00000004 20700008 00000004 30500008
00000002 40200008
// 6: fresh pass after the abort, nothing left from test 5
0 20 3 0
00000004 01010025 00000005 02020030 00000004 03030010
3ffff 3ffff 3ffff 30d40 30d43 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
2
ffffffff

// ==== tb.f ====
blob_sort_pkg.sv
blob_sort_ctrl.sv
blob_fetch.sv
rank_table.sv
blob_sort_top.sv
blob_sort_sva.sv
tb_clock_gen.sv
tb_blob_sort.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_blob_sort -o sim_blob_sort

status=0
./obj_dir/sim_blob_sort > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
